//--- acq_pkg.sv
package acq_pkg;

    //////////////////////////////////////////////////////////////////////
    // constants

    localparam int BURST_PAIRS = 4;              // sample pairs per burst, fixed by payload width

    localparam logic [3:0] TAG_HDR = 4'h1;       // output word carries a fill header
    localparam logic [3:0] TAG_DAT = 4'h2;       // output word carries adc data

    //////////////////////////////////////////////////////////////////////
    // sample types

    typedef struct packed {
        logic [11:0] sample_b;                   // second adc sample
        logic        ovr_b;                      // second over-range
        logic [11:0] sample_a;                   // first adc sample
        logic        ovr_a;                      // first over-range
    } pair_t;

    typedef pair_t [BURST_PAIRS-1:0] burst_t;    // index 0 holds the oldest pair

    typedef enum logic [1:0] {
        FILL_NONE  = 2'd0,                       // not enabled, triggers ignored
        FILL_MUON  = 2'd1,
        FILL_LASER = 2'd2,
        FILL_PED   = 2'd3
    } fill_type_e;

    typedef logic [22:0] burst_cnt_t;            // bursts per fill
    typedef logic [23:0] fill_num_t;             // running fill number

    //////////////////////////////////////////////////////////////////////
    // output word

    typedef struct packed {
        logic [15:0] channel_tag;                // channel info copied into each header
        fill_type_e  fill_type;
        burst_cnt_t  num_bursts;                 // data words that follow this header
        fill_num_t   fill_num;
        logic [62:0] pad;                        // always zero
    } hdr_t;

    typedef struct packed {
        burst_t      pairs;                      // four pairs, pairs[0] oldest
        logic [23:0] pad;                        // always zero
    } dat_t;

    typedef union packed {
        hdr_t hdr;                               // valid when tag is TAG_HDR
        dat_t dat;                               // valid when tag is TAG_DAT
    } payload_u;

    typedef struct packed {
        logic [3:0] tag;
        payload_u   payload;
    } acq_word_t;

    typedef struct packed {
        logic load_params;                       // latch fill params for a new fill
        logic emit_hdr;                          // register a header word
        logic emit_dat;                          // register a data word
        logic burst_dec;                         // one burst sent
        logic fill_inc;                          // fill finished
        logic pattern_clear;                     // restart test pattern
    } ctl_t;

endpackage

//--- sample_pipe.sv
module sample_pipe (
    input  logic           adc_clk,
    input  logic           dummy_dat_reset,
    input  acq_pkg::pair_t adc_dat,              // captured sample pair
    input  logic           pattern_sel,          // 1 selects the counting test pattern
    input  logic           pattern_clear,        // restart pattern at fill start
    output acq_pkg::burst_t burst,               // last four pairs, burst[0] oldest
    output logic           burst_tick            // burst holds four fresh pairs
);
    import acq_pkg::*;

    localparam int PW = $clog2(BURST_PAIRS);

    logic [11:0]   pattern_cnt;                  // test pattern counter
    logic [PW-1:0] phase;                        // pairs shifted in since last tick
    pair_t         pair_new;                     // value for the newest register

    //////////////////////////////////////////////////////////////////////
    // test pattern counter

    always_ff @(posedge adc_clk) begin
        if (dummy_dat_reset || pattern_clear) begin
            pattern_cnt <= '0;
        end else begin
            pattern_cnt <= pattern_cnt + 12'd1; // runs every clock
        end
    end

    always_comb begin
        if (pattern_sel) begin
            pair_new.sample_b = ~pattern_cnt;    // inverted counter
            pair_new.ovr_b    = 1'b0;
            pair_new.sample_a = pattern_cnt;     // plain counter
            pair_new.ovr_a    = 1'b0;
        end else begin
            pair_new = adc_dat;                  // real samples
        end
    end

    //////////////////////////////////////////////////////////////////////
    // burst shift register and phase

    always_ff @(posedge adc_clk) begin
        burst <= {pair_new, burst[BURST_PAIRS-1:1]}; // newest in at the top
    end

    always_ff @(posedge adc_clk) begin
        if (dummy_dat_reset) begin
            phase      <= '0;
            burst_tick <= 1'b0;
        end else begin
            phase      <= phase + 1'b1;          // wraps every BURST_PAIRS cycles
            burst_tick <= (phase == PW'(BURST_PAIRS - 1)); // fourth pair going in now
        end
    end

endmodule

//--- fill_param_mux.sv
module fill_param_mux (
    input  logic                adc_clk,
    input  logic                acq_enable0,
    input  logic                acq_enable1,
    input  acq_pkg::burst_cnt_t muon_num_bursts,
    input  acq_pkg::burst_cnt_t laser_num_bursts,
    input  acq_pkg::burst_cnt_t ped_num_bursts,
    input  logic                load_params,     // fill start
    output acq_pkg::fill_type_e fill_type,       // held for the whole fill
    output acq_pkg::burst_cnt_t num_bursts,      // held for the whole fill
    output logic                acq_enabled      // live, any fill type enabled
);
    import acq_pkg::*;

    fill_type_e type_live;                       // decoded from the enable pins
    burst_cnt_t bursts_live;                     // count for the live type

    assign type_live   = fill_type_e'({acq_enable1, acq_enable0});
    assign acq_enabled = (type_live != FILL_NONE);

    always_comb begin
        case (type_live)
            FILL_MUON:  bursts_live = muon_num_bursts;
            FILL_LASER: bursts_live = laser_num_bursts;
            FILL_PED:   bursts_live = ped_num_bursts;
            default:    bursts_live = '0;        // none enabled
        endcase
    end

    always_ff @(posedge adc_clk) begin
        if (load_params) begin
            fill_type  <= type_live;
            num_bursts <= bursts_live;
        end
    end

endmodule

//--- acq_counters.sv
module acq_counters (
    input  logic                adc_clk,
    input  logic                dummy_dat_reset,
    input  acq_pkg::burst_cnt_t num_bursts,      // latched count from the param mux
    input  logic                load_params,
    input  logic                burst_dec,
    input  logic                fill_inc,
    input  acq_pkg::fill_num_t  initial_fill_num,
    input  logic                initial_fill_num_wr,
    output logic                burst_zero,      // no bursts left in this fill
    output acq_pkg::fill_num_t  fill_num
);
    import acq_pkg::*;

    logic       load_d;                          // num_bursts settles one cycle after load
    burst_cnt_t burst_cnt;                       // bursts still to send

    always_ff @(posedge adc_clk) begin
        if (dummy_dat_reset) begin
            load_d    <= 1'b0;
            burst_cnt <= '0;
        end else begin
            load_d <= load_params;
            if (load_d) begin
                burst_cnt <= num_bursts;
            end else if (burst_dec && (burst_cnt != '0)) begin
                burst_cnt <= burst_cnt - 1'b1;   // one burst out
            end
        end
    end

    assign burst_zero = (burst_cnt == '0);

    //////////////////////////////////////////////////////////////////////
    // fill number

    always_ff @(posedge adc_clk) begin
        if (dummy_dat_reset) begin
            fill_num <= '0;
        end else if (initial_fill_num_wr) begin
            fill_num <= initial_fill_num;        // host write wins
        end else if (fill_inc) begin
            fill_num <= fill_num + 1'b1;
        end
    end

endmodule

//--- acq_ctrl_sm.sv
module acq_ctrl_sm (
    input  logic                adc_clk,
    input  logic                dummy_dat_reset,
    input  logic                acq_reset,       // abort the current fill
    input  logic                acq_trig,        // req of the trigger handshake
    input  acq_pkg::fill_type_e fill_type,       // live fill type
    input  logic                pattern_reset_mode, // channel_tag bit 4
    input  logic                burst_zero,
    input  logic                burst_tick,
    output acq_pkg::ctl_t       ctl,
    output logic                acq_done,        // ack of the trigger handshake
    output logic                sm_idle
);
    import acq_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_HDR,
        ST_BURST,
        ST_DONE
    } state_e;

    state_e state;
    state_e state_nxt;
    logic   req_armed;                           // req seen low since last fill
    logic   primed;                              // first tick of the fill passed
    logic   accept;                              // trigger taken this cycle

    assign accept = (state == ST_IDLE) && acq_trig && req_armed && (fill_type != FILL_NONE);

    //////////////////////////////////////////////////////////////////////
    // next state and control strobes

    always_comb begin
        state_nxt = state;
        ctl       = '0;
        case (state)
            ST_IDLE: begin
                if (accept) begin
                    state_nxt = ST_LOAD;
                end
            end
            ST_LOAD: begin
                ctl.load_params   = 1'b1;
                ctl.pattern_clear = pattern_reset_mode; // pattern restarts per fill
                state_nxt         = ST_HDR;
            end
            ST_HDR: begin
                ctl.emit_hdr = 1'b1;
                state_nxt    = ST_BURST;
            end
            ST_BURST: begin
                if (burst_zero) begin
                    ctl.fill_inc = 1'b1;         // last word already out
                    state_nxt    = ST_DONE;
                end else if (burst_tick && primed) begin
                    ctl.emit_dat  = 1'b1;
                    ctl.burst_dec = 1'b1;
                end
            end
            ST_DONE: begin
                if (!acq_trig) begin
                    state_nxt = ST_IDLE;         // req dropped, release ack
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
        if (acq_reset) begin
            state_nxt = ST_IDLE;                 // abort from any state
            ctl       = '0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // state registers

    always_ff @(posedge adc_clk) begin
        if (dummy_dat_reset) begin
            state     <= ST_IDLE;
            req_armed <= 1'b0;
            primed    <= 1'b0;
        end else begin
            state <= state_nxt;
            if (!acq_trig) begin
                req_armed <= 1'b1;
            end else if (state == ST_LOAD) begin
                req_armed <= 1'b0;               // trigger consumed
            end
            // skip the first tick so every burst holds post-trigger samples only
            if (state == ST_HDR) begin
                primed <= 1'b0;
            end else if ((state == ST_BURST) && burst_tick) begin
                primed <= 1'b1;
            end
        end
    end

    assign acq_done = (state == ST_DONE);
    assign sm_idle  = (state == ST_IDLE);

endmodule

//--- acq_word_mux.sv
module acq_word_mux (
    input  logic                adc_clk,
    input  logic                dummy_dat_reset,
    input  logic                emit_hdr,
    input  logic                emit_dat,
    input  logic [15:0]         channel_tag,
    input  acq_pkg::fill_type_e fill_type,
    input  acq_pkg::burst_cnt_t num_bursts,
    input  acq_pkg::fill_num_t  fill_num,
    input  acq_pkg::burst_t     burst,           // burst[0] oldest pair
    output acq_pkg::acq_word_t  out_dat,
    output logic                out_valid
);
    import acq_pkg::*;

    hdr_t      hdr_w;                            // header view of the payload
    dat_t      dat_w;                            // data view of the payload
    acq_word_t word_nxt;

    //////////////////////////////////////////////////////////////////////
    // build both views, the tag picks one

    always_comb begin
        hdr_w             = '0;
        hdr_w.channel_tag = channel_tag;
        hdr_w.fill_type   = fill_type;
        hdr_w.num_bursts  = num_bursts;
        hdr_w.fill_num    = fill_num;

        dat_w       = '0;
        dat_w.pairs = burst;                     // keeps oldest at index 0

        if (emit_hdr) begin
            word_nxt.tag         = TAG_HDR;
            word_nxt.payload.hdr = hdr_w;
        end else begin
            word_nxt.tag         = TAG_DAT;
            word_nxt.payload.dat = dat_w;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output register

    always_ff @(posedge adc_clk) begin
        if (emit_hdr || emit_dat) begin
            out_dat <= word_nxt;                 // holds last word between strobes
        end
    end

    always_ff @(posedge adc_clk) begin
        if (dummy_dat_reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= emit_hdr | emit_dat;    // one cycle per word
        end
    end

endmodule

//--- adc_acq_top.sv
module adc_acq_top (
    input  logic                adc_clk,
    input  logic                dummy_dat_reset,
    input  acq_pkg::pair_t      adc_dat,         // one captured pair per clock
    input  logic [15:0]         channel_tag,     // bit 3 pattern select, bit 4 pattern clear mode
    input  acq_pkg::burst_cnt_t muon_num_bursts,
    input  acq_pkg::burst_cnt_t laser_num_bursts,
    input  acq_pkg::burst_cnt_t ped_num_bursts,
    input  acq_pkg::fill_num_t  initial_fill_num,
    input  logic                initial_fill_num_wr,
    input  logic                acq_enable0,
    input  logic                acq_enable1,
    input  logic                acq_trig,        // req
    input  logic                acq_reset,       // abort
    output logic                acq_enabled,
    output acq_pkg::fill_num_t  fill_num,
    output acq_pkg::acq_word_t  adc_acq_out_dat,
    output logic                adc_acq_out_valid,
    output logic                acq_done,        // ack
    output logic                adc_acq_sm_idle
);
    import acq_pkg::*;

    ctl_t       ctl;                             // strobes from the state machine
    fill_type_e trig_type;                       // live type for trigger accept
    fill_type_e fill_type;                       // latched type for the header
    burst_cnt_t num_bursts;
    logic       burst_zero;
    burst_t     burst;
    logic       burst_tick;

    assign trig_type = fill_type_e'({acq_enable1, acq_enable0});

    acq_ctrl_sm u_ctrl_sm (
        .adc_clk            (adc_clk),
        .dummy_dat_reset    (dummy_dat_reset),
        .acq_reset          (acq_reset),
        .acq_trig           (acq_trig),
        .fill_type          (trig_type),
        .pattern_reset_mode (channel_tag[4]),
        .burst_zero         (burst_zero),
        .burst_tick         (burst_tick),
        .ctl                (ctl),
        .acq_done           (acq_done),
        .sm_idle            (adc_acq_sm_idle)
    );

    fill_param_mux u_fill_param_mux (
        .adc_clk          (adc_clk),
        .acq_enable0      (acq_enable0),
        .acq_enable1      (acq_enable1),
        .muon_num_bursts  (muon_num_bursts),
        .laser_num_bursts (laser_num_bursts),
        .ped_num_bursts   (ped_num_bursts),
        .load_params      (ctl.load_params),
        .fill_type        (fill_type),
        .num_bursts       (num_bursts),
        .acq_enabled      (acq_enabled)
    );

    acq_counters u_counters (
        .adc_clk             (adc_clk),
        .dummy_dat_reset     (dummy_dat_reset),
        .num_bursts          (num_bursts),
        .load_params         (ctl.load_params),
        .burst_dec           (ctl.burst_dec),
        .fill_inc            (ctl.fill_inc),
        .initial_fill_num    (initial_fill_num),
        .initial_fill_num_wr (initial_fill_num_wr),
        .burst_zero          (burst_zero),
        .fill_num            (fill_num)
    );

    sample_pipe u_sample_pipe (
        .adc_clk         (adc_clk),
        .dummy_dat_reset (dummy_dat_reset),
        .adc_dat         (adc_dat),
        .pattern_sel     (channel_tag[3]),
        .pattern_clear   (ctl.pattern_clear),
        .burst           (burst),
        .burst_tick      (burst_tick)
    );

    acq_word_mux u_word_mux (
        .adc_clk         (adc_clk),
        .dummy_dat_reset (dummy_dat_reset),
        .emit_hdr        (ctl.emit_hdr),
        .emit_dat        (ctl.emit_dat),
        .channel_tag     (channel_tag),
        .fill_type       (fill_type),
        .num_bursts      (num_bursts),
        .fill_num        (fill_num),
        .burst           (burst),
        .out_dat         (adc_acq_out_dat),
        .out_valid       (adc_acq_out_valid)
    );

endmodule

//--- tb_adc_acq_ref.svh
`ifndef TB_ADC_ACQ_REF_SVH
`define TB_ADC_ACQ_REF_SVH

//////////////////////////////////////////////////////////////////////
// reference model of the output stream

function automatic acq_word_t expected_hdr(input logic [15:0] tag16, input fill_type_e ft,
                                           input burst_cnt_t nb, input fill_num_t fn);
    acq_word_t w;
    w                         = '0;              // padding stays zero
    w.tag                     = TAG_HDR;
    w.payload.hdr.channel_tag = tag16;
    w.payload.hdr.fill_type   = ft;
    w.payload.hdr.num_bursts  = nb;
    w.payload.hdr.fill_num    = fn;
    return w;
endfunction

// four pairs from sample index start with the oldest at index 0
function automatic acq_word_t expected_dat(input logic [11:0] start, input bit pattern);
    acq_word_t   w;
    logic [11:0] s;
    int          i;
    w     = '0;
    w.tag = TAG_DAT;
    for (i = 0; i < BURST_PAIRS; i++) begin
        s = start + 12'(i);
        if (pattern) begin
            w.payload.dat.pairs[i].sample_a = s;  // counter
            w.payload.dat.pairs[i].sample_b = ~s; // inverted counter with ovr bits left zero
        end else begin
            w.payload.dat.pairs[i] = driven[s]; // what the tb put on adc_dat
        end
    end
    return w;
endfunction

// next pair is the one sampled one clock later
function automatic bit pair_continues(input pair_t prev, input pair_t next);
    return next.sample_a == prev.sample_a + 12'd1;
endfunction

//////////////////////////////////////////////////////////////////////
// compare tasks

task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("TEST FAIL");
    $fatal(1, "stopped at first error");
endtask

task automatic check_word(input string name, input acq_word_t exp, input acq_word_t act);
    if (act !== exp) begin
        stop_on_error($sformatf("ERROR %s expected %h actual %h", name, exp, act));
    end
endtask

task automatic check_fill_num(input string name, input fill_num_t exp, input fill_num_t act);
    if (act !== exp) begin
        stop_on_error($sformatf("ERROR %s expected %h actual %h", name, exp, act));
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        stop_on_error($sformatf("ERROR %s expected %b actual %b", name, exp, act));
    end
endtask

`endif

//--- tb_adc_acq.sv
module tb_adc_acq;
    import acq_pkg::*;

    logic        adc_clk;
    logic        dummy_dat_reset;
    pair_t       adc_dat;
    logic [15:0] channel_tag;
    burst_cnt_t  muon_num_bursts;
    burst_cnt_t  laser_num_bursts;
    burst_cnt_t  ped_num_bursts;
    fill_num_t   initial_fill_num;
    logic        initial_fill_num_wr;
    logic        acq_enable0;
    logic        acq_enable1;
    logic        acq_trig;
    logic        acq_reset;
    logic        acq_enabled;
    fill_num_t   fill_num;
    acq_word_t   adc_acq_out_dat;
    logic        adc_acq_out_valid;
    logic        acq_done;
    logic        adc_acq_sm_idle;

    integer      seed;                           // $random state
    integer      rnd;
    logic [11:0] dat_cnt;                        // tb sample counter
    pair_t       next_pair;
    pair_t       driven [0:4095];                // driven pairs by sample_a
    int unsigned cyc;                            // clock counter
    fill_num_t   fill_expect;                    // running model of fill_num

    fill_type_e  exp_type;                       // current fill as the header must show it
    burst_cnt_t  exp_bursts;
    fill_num_t   exp_fill_num;
    bit          exp_pattern;

    int          hdr_count;                      // words seen by the monitor this fill
    int          dat_count;
    bit          first_dat;                      // next data word opens the fill
    pair_t       last_pair;                      // newest pair of the previous data word
    int unsigned last_dat_cyc;
    int unsigned last_valid_cyc;
    logic        done_d;

    `include "tb_adc_acq_ref.svh"

    adc_acq_top u_dut (
        .adc_clk             (adc_clk),
        .dummy_dat_reset     (dummy_dat_reset),
        .adc_dat             (adc_dat),
        .channel_tag         (channel_tag),
        .muon_num_bursts     (muon_num_bursts),
        .laser_num_bursts    (laser_num_bursts),
        .ped_num_bursts      (ped_num_bursts),
        .initial_fill_num    (initial_fill_num),
        .initial_fill_num_wr (initial_fill_num_wr),
        .acq_enable0         (acq_enable0),
        .acq_enable1         (acq_enable1),
        .acq_trig            (acq_trig),
        .acq_reset           (acq_reset),
        .acq_enabled         (acq_enabled),
        .fill_num            (fill_num),
        .adc_acq_out_dat     (adc_acq_out_dat),
        .adc_acq_out_valid   (adc_acq_out_valid),
        .acq_done            (acq_done),
        .adc_acq_sm_idle     (adc_acq_sm_idle)
    );

    initial begin
        adc_clk = 1'b0;
        forever begin
            #50 adc_clk = ~adc_clk;              // period 100
        end
    end

    always @(posedge adc_clk) begin
        cyc <= cyc + 1;
    end

    // one new pair per clock with random ovr bits
    always @(negedge adc_clk) begin
        dat_cnt            = dat_cnt + 12'd1;
        rnd                = $random(seed);
        next_pair.sample_a = dat_cnt;
        next_pair.sample_b = dat_cnt ^ 12'h5a5;  // differs from sample_a
        next_pair.ovr_a    = rnd[0];
        next_pair.ovr_b    = rnd[1];
        driven[dat_cnt]    = next_pair;
        adc_dat            = next_pair;
    end

    //////////////////////////////////////////////////////////////////////
    // monitor of every valid word against the reference

    always @(negedge adc_clk) begin
        if (!dummy_dat_reset) begin
            if (adc_acq_out_valid) begin
                last_valid_cyc = cyc;
                if (adc_acq_out_dat.tag == TAG_HDR) begin
                    check_word("header", expected_hdr(channel_tag, exp_type, exp_bursts,
                               exp_fill_num), adc_acq_out_dat);
                    hdr_count++;
                    first_dat = 1'b1;
                end else begin
                    if (!first_dat) begin
                        check_bit("data word spacing", 1'b1,
                                  (cyc - last_dat_cyc) == BURST_PAIRS);
                        check_bit("pair sequence across words", 1'b1,
                                  pair_continues(last_pair, adc_acq_out_dat.payload.dat.pairs[0]));
                    end else if (exp_pattern && channel_tag[4]) begin
                        check_bit("pattern restart at fill start", 1'b1,
                                  (adc_acq_out_dat.payload.dat.pairs[0].sample_a >= 1) &&
                                  (adc_acq_out_dat.payload.dat.pairs[0].sample_a <= BURST_PAIRS));
                    end
                    check_word("data", expected_dat(adc_acq_out_dat.payload.dat.pairs[0].sample_a,
                               exp_pattern), adc_acq_out_dat);
                    first_dat    = 1'b0;
                    last_pair    = adc_acq_out_dat.payload.dat.pairs[BURST_PAIRS-1];
                    last_dat_cyc = cyc;
                    dat_count++;
                end
            end
            if (acq_done && !done_d) begin
                check_bit("acq_done one cycle after last word", 1'b1, cyc == last_valid_cyc + 1);
            end
            done_d = acq_done;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // sequence helpers

    task automatic wait_valid(input int limit, input string what);
        int n;
        n = 0;
        while (adc_acq_out_valid !== 1'b1) begin
            if (n == limit) stop_on_error({"timeout waiting for ", what});
            @(negedge adc_clk);
            n++;
        end
    endtask

    task automatic wait_done(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (acq_done !== level) begin
            if (n == limit) stop_on_error({"timeout waiting for ", what});
            @(negedge adc_clk);
            n++;
        end
    endtask

    task automatic wait_words(input int count, input int limit);
        int seen;
        int n;
        seen = 0;
        n    = 0;
        while (seen < count) begin
            if (n == limit) stop_on_error("timeout waiting for output words");
            @(negedge adc_clk);
            n++;
            if (adc_acq_out_valid) seen++;
        end
    endtask

    task automatic setup_fill(input fill_type_e ft, input burst_cnt_t nb, input logic [15:0] tag16);
        case (ft)
            FILL_MUON:  muon_num_bursts  = nb;
            FILL_LASER: laser_num_bursts = nb;
            FILL_PED:   ped_num_bursts   = nb;
            default:    muon_num_bursts  = nb;
        endcase
        {acq_enable1, acq_enable0} = ft;
        channel_tag  = tag16;
        exp_type     = ft;
        exp_bursts   = nb;
        exp_fill_num = fill_expect;
        exp_pattern  = tag16[3];
        hdr_count    = 0;
        dat_count    = 0;
        @(negedge adc_clk);
        check_bit("acq_enabled", 1'b1, acq_enabled);
    endtask

    task automatic run_fill(input fill_type_e ft, input burst_cnt_t nb, input logic [15:0] tag16);
        setup_fill(ft, nb, tag16);
        acq_trig = 1'b1;                         // req
        wait_valid(4, "header");
        wait_done(1'b1, BURST_PAIRS * (int'(nb) + 3) + 8, "acq_done rise");
        check_bit("one header per fill", 1'b1, hdr_count == 1);
        check_bit("data words per fill", 1'b1, dat_count == int'(nb));
        fill_expect = fill_expect + 1'b1;
        check_fill_num("fill_num after fill", fill_expect, fill_num);
        repeat (3) begin
            @(negedge adc_clk);
            check_bit("acq_done held while req high", 1'b1, acq_done);
        end
        acq_trig = 1'b0;
        wait_done(1'b0, 2, "acq_done fall");
        check_bit("idle after fill", 1'b1, adc_acq_sm_idle);
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        seed                = 32'hdd65;
        cyc                 = 0;
        dat_cnt             = 12'd0;
        adc_dat             = '0;
        driven[0]           = '0;
        channel_tag         = '0;
        muon_num_bursts     = '0;
        laser_num_bursts    = '0;
        ped_num_bursts      = '0;
        initial_fill_num    = '0;
        initial_fill_num_wr = 1'b0;
        acq_enable0         = 1'b0;
        acq_enable1         = 1'b0;
        acq_trig            = 1'b0;
        acq_reset           = 1'b0;
        fill_expect         = '0;
        first_dat           = 1'b1;
        done_d              = 1'b0;
        dummy_dat_reset     = 1'b1;
        repeat (4) @(negedge adc_clk);
        dummy_dat_reset = 1'b0;
        @(negedge adc_clk);
        check_bit("acq_done after reset", 1'b0, acq_done);
        check_bit("valid after reset", 1'b0, adc_acq_out_valid);
        check_bit("idle after reset", 1'b1, adc_acq_sm_idle);
        check_fill_num("fill_num after reset", fill_expect, fill_num);

        initial_fill_num    = 24'h00_1230;
        initial_fill_num_wr = 1'b1;
        @(negedge adc_clk);
        initial_fill_num_wr = 1'b0;
        fill_expect         = 24'h00_1230;
        check_fill_num("fill_num write", fill_expect, fill_num);

        run_fill(FILL_MUON, 23'd3, 16'h0a01);    // real samples
        run_fill(FILL_LASER, 23'd0, 16'h0b02);   // header only
        run_fill(FILL_PED, 23'd2, 16'h0c08);     // test pattern
        run_fill(FILL_MUON, 23'd3, 16'h0d18);    // pattern restarted per fill

        // req ignored with both enables low
        {acq_enable1, acq_enable0} = 2'b00;
        @(negedge adc_clk);
        check_bit("acq_enabled off", 1'b0, acq_enabled);
        acq_trig = 1'b1;
        repeat (10) begin
            @(negedge adc_clk);
            check_bit("no word without enable", 1'b0, adc_acq_out_valid);
            check_bit("idle without enable", 1'b1, adc_acq_sm_idle);
        end
        acq_trig = 1'b0;
        check_fill_num("fill_num without enable", fill_expect, fill_num);

        // abort in the middle of the bursts
        setup_fill(FILL_MUON, 23'd6, 16'h0e01);
        acq_trig = 1'b1;
        wait_words(3, 40);                       // header and two data words
        acq_reset = 1'b1;
        @(negedge adc_clk);
        acq_reset = 1'b0;
        check_bit("idle after abort", 1'b1, adc_acq_sm_idle);
        repeat (12) begin
            @(negedge adc_clk);
            check_bit("no word after abort", 1'b0, adc_acq_out_valid);
            check_bit("acq_done after abort", 1'b0, acq_done);
        end
        check_fill_num("fill_num after abort", fill_expect, fill_num);
        acq_trig = 1'b0;
        @(negedge adc_clk);

        run_fill(FILL_PED, 23'd1, 16'h0f00);     // fresh fill after the abort

        $display("TEST PASS");
        $finish;
    end

endmodule

//--- src.f
+incdir+.
acq_pkg.sv
sample_pipe.sv
fill_param_mux.sv
acq_counters.sv
acq_ctrl_sm.sv
acq_word_mux.sv
adc_acq_top.sv
tb_adc_acq.sv
